// ==== hw/div_unit.sv ====
`include "muldiv_consts.svh"

module div_unit (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_start,
  input  muldiv_op_pkg::op_t        i_op,
  input  muldiv_op_pkg::operands_t  i_src,
  input  muldiv_tag_pkg::rd_tag_t   i_tag,
  input  logic                      i_taken,
  output logic                      o_busy,
  output logic                      o_done,
  output logic [`MD_XLEN-1:0]       o_res,
  output muldiv_tag_pkg::rd_tag_t   o_tag
);

  localparam int XLEN = `MD_XLEN;
  localparam int CW   = $clog2(XLEN);

  typedef enum logic [2:0] {IDLE, SETUP, ITER, FIXUP, HOLD} state_t;

  state_t                   r_state;
  logic [CW-1:0]            r_cnt;
  muldiv_op_pkg::op_t       r_op;
  muldiv_tag_pkg::rd_tag_t  r_tag;
  muldiv_op_pkg::operands_t r_src;      // raw operands
  logic [XLEN-1:0]          r_divisor;  // magnitude
  logic [XLEN-1:0]          r_quo;
  logic [XLEN-1:0]          r_rem;
  logic [XLEN-1:0]          r_res;

  logic                     w_signed;
  logic                     w_is_rem;
  logic                     w_neg_a;
  logic                     w_neg_b;
  logic                     w_div_zero;
  logic                     w_ovf;
  logic [XLEN:0]            w_rem_sh;
  logic [XLEN:0]            w_sub;
  logic                     w_ge;
  logic [XLEN-1:0]          w_quo_s;
  logic [XLEN-1:0]          w_rem_s;
  logic [XLEN-1:0]          w_fix_res;

  assign w_signed   = (r_op == muldiv_op_pkg::OP_DIV) || (r_op == muldiv_op_pkg::OP_REM);
  assign w_is_rem   = (r_op == muldiv_op_pkg::OP_REM) || (r_op == muldiv_op_pkg::OP_REMU);
  assign w_neg_a    = w_signed & r_src.rs1[XLEN-1];
  assign w_neg_b    = w_signed & r_src.rs2[XLEN-1];
  assign w_div_zero = (r_src.rs2 == '0);
  assign w_ovf      = w_signed && (r_src.rs1 == {1'b1, {(XLEN-1){1'b0}}}) && (&r_src.rs2);

  // restoring step
  assign w_rem_sh = {r_rem, r_quo[XLEN-1]};
  assign w_ge     = (w_rem_sh >= {1'b0, r_divisor});
  assign w_sub    = w_rem_sh - {1'b0, r_divisor};

  // ==========================================================================
  // sign fixup and RISC-V special cases
  // ==========================================================================
  always_comb begin
    w_quo_s = (w_neg_a ^ w_neg_b) ? -r_quo : r_quo;
    w_rem_s = w_neg_a ? -r_rem : r_rem;  // remainder follows dividend
    if (w_div_zero) begin
      w_fix_res = w_is_rem ? r_src.rs1 : '1;
    end else if (w_ovf) begin
      w_fix_res = w_is_rem ? '0 : r_src.rs1;
    end else begin
      w_fix_res = w_is_rem ? w_rem_s : w_quo_s;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
      r_cnt   <= '0;
    end else begin
      case (r_state)
        IDLE:    if (i_start) r_state <= (i_src.rs2 == '0) ? FIXUP : SETUP;
        SETUP: begin
          r_state <= ITER;
          r_cnt   <= '0;
        end
        ITER: begin
          r_cnt <= r_cnt + 1'b1;
          if (r_cnt == CW'(XLEN - 1)) r_state <= FIXUP;
        end
        FIXUP:   r_state <= HOLD;
        HOLD:    if (i_taken) r_state <= IDLE;
        default: r_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    case (r_state)
      IDLE: begin
        r_op  <= i_op;
        r_tag <= i_tag;
        r_src <= i_src;
      end
      SETUP: begin
        r_quo     <= w_neg_a ? -r_src.rs1 : r_src.rs1;
        r_divisor <= w_neg_b ? -r_src.rs2 : r_src.rs2;
        r_rem     <= '0;
      end
      ITER: begin
        r_rem <= w_ge ? w_sub[XLEN-1:0] : w_rem_sh[XLEN-1:0];
        r_quo <= {r_quo[XLEN-2:0], w_ge};
      end
      FIXUP:   r_res <= w_fix_res;
      default: ;
    endcase
  end

  assign o_busy = (r_state == SETUP) || (r_state == ITER) || (r_state == FIXUP);
  assign o_done = (r_state == HOLD);
  assign o_res  = r_res;
  assign o_tag  = r_tag;

endmodule

// ==== hw/mul_pipe.sv ====
`include "muldiv_consts.svh"

module mul_pipe (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_start,
  input  muldiv_op_pkg::op_t        i_op,
  input  muldiv_op_pkg::operands_t  i_src,
  input  muldiv_tag_pkg::rd_tag_t   i_tag,
  output logic                      o_mul_valid,
  output logic [2*`MD_XLEN-1:0]     o_mul_prod,
  output muldiv_op_pkg::op_t        o_mul_op,
  output muldiv_tag_pkg::rd_tag_t   o_mul_tag
);

  localparam int XLEN   = `MD_XLEN;
  localparam int UNROLL = `MD_MUL_UNROLL;
  localparam int STAGES = `MD_MUL_STAGES;
  localparam int PW     = 2 * XLEN;

  typedef struct packed {
    muldiv_op_pkg::op_t      op;
    logic [XLEN:0]           mplier;  // rs1, extended to 33 bits
    logic [XLEN:0]           mcand;   // rs2, extended to 33 bits
    logic [PW-1:0]           acc;     // partial sum
    muldiv_tag_pkg::rd_tag_t tag;
  } stage_t;

  logic                w_signed_rs1;
  logic                w_signed_rs2;
  stage_t              w_issue;
  stage_t              r_stage [STAGES];
  logic [STAGES-1:0]   r_valid;

  assign w_signed_rs1 = (i_op == muldiv_op_pkg::OP_MUL) ||
                        (i_op == muldiv_op_pkg::OP_MULH) ||
                        (i_op == muldiv_op_pkg::OP_MULHSU);
  assign w_signed_rs2 = (i_op == muldiv_op_pkg::OP_MUL) ||
                        (i_op == muldiv_op_pkg::OP_MULH);

  always_comb begin
    w_issue.op     = i_op;
    w_issue.mplier = {w_signed_rs1 & i_src.rs1[XLEN-1], i_src.rs1};
    w_issue.mcand  = {w_signed_rs2 & i_src.rs2[XLEN-1], i_src.rs2};
    w_issue.acc    = '0;
    w_issue.tag    = i_tag;
  end

  // ==========================================================================
  // one multiplier digit per stage
  // ==========================================================================
  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    stage_t               w_in;
    stage_t               w_next;
    logic [UNROLL:0]      w_digit;
    logic signed [PW-1:0] w_mcand_x;
    logic signed [PW-1:0] w_digit_x;
    logic [PW-1:0]        w_pp;

    if (s == 0) begin : g_first
      assign w_in = w_issue;
    end else begin : g_rest
      assign w_in = r_stage[s-1];
    end

    if (s == STAGES - 1) begin : g_top_digit
      // sign bit weighs -2^XLEN
      assign w_digit = {w_in.mplier[XLEN], w_in.mplier[UNROLL*s +: UNROLL]};
    end else begin : g_low_digit
      assign w_digit = {1'b0, w_in.mplier[UNROLL*s +: UNROLL]};
    end

    assign w_mcand_x = $signed(w_in.mcand);
    assign w_digit_x = $signed(w_digit);
    assign w_pp      = w_mcand_x * w_digit_x;  // low PW bits are enough

    always_comb begin
      w_next     = w_in;
      w_next.acc = w_in.acc + (w_pp << (UNROLL * s));
    end

    always_ff @(posedge i_clk) begin
      r_stage[s] <= w_next;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      r_valid <= {r_valid[STAGES-2:0], i_start};
    end
  end

  assign o_mul_valid = r_valid[STAGES-1];
  assign o_mul_prod  = r_stage[STAGES-1].acc;
  assign o_mul_op    = r_stage[STAGES-1].op;
  assign o_mul_tag   = r_stage[STAGES-1].tag;

endmodule

// ==== hw/muldiv_consts.svh ====
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// operand width
`define MD_XLEN 32

// destination tag fields
`define MD_RNID_W 6
`define MD_ENTRY_N 8

// multiplier slicing
// MD_MUL_UNROLL * MD_MUL_STAGES must cover MD_XLEN
`define MD_MUL_UNROLL 8
`define MD_MUL_STAGES 4

`endif

// ==== hw/muldiv_op_pkg.sv ====
`include "muldiv_consts.svh"

package muldiv_op_pkg;

  // encoded as the RV32M funct3 field
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } op_t;

  typedef struct packed {
    logic [`MD_XLEN-1:0] rs1;
    logic [`MD_XLEN-1:0] rs2;
  } operands_t;

endpackage

// ==== hw/muldiv_pipe.sv ====
`include "muldiv_consts.svh"

module muldiv_pipe (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_valid,
  input  muldiv_op_pkg::op_t        i_op,
  input  muldiv_op_pkg::operands_t  i_src,
  input  muldiv_tag_pkg::rd_tag_t   i_tag,
  output logic                      o_stall,
  output logic                      o_valid,
  output logic [`MD_XLEN-1:0]       o_res,
  output muldiv_tag_pkg::rd_tag_t   o_tag
);

  logic                     w_is_mul;
  logic                     w_mul_start;
  logic                     w_div_start;
  logic                     w_mul_valid;
  logic [2*`MD_XLEN-1:0]    w_mul_prod;
  muldiv_op_pkg::op_t       w_mul_op;
  muldiv_tag_pkg::rd_tag_t  w_mul_tag;
  logic                     w_div_busy;
  logic                     w_div_done;
  logic                     w_div_taken;
  logic [`MD_XLEN-1:0]      w_div_res;
  muldiv_tag_pkg::rd_tag_t  w_div_tag;

  assign w_is_mul    = i_op inside {muldiv_op_pkg::OP_MUL, muldiv_op_pkg::OP_MULH,
                                    muldiv_op_pkg::OP_MULHSU, muldiv_op_pkg::OP_MULHU};
  assign w_mul_start = i_valid & w_is_mul;
  assign w_div_start = i_valid & ~w_is_mul;
  assign o_stall     = w_div_busy | w_div_done;  // one divide at a time

  mul_pipe u_mul_pipe (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_start(w_mul_start), .i_op(i_op),
    .i_src(i_src), .i_tag(i_tag), .o_mul_valid(w_mul_valid), .o_mul_prod(w_mul_prod),
    .o_mul_op(w_mul_op), .o_mul_tag(w_mul_tag)
  );

  div_unit u_div_unit (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_start(w_div_start), .i_op(i_op),
    .i_src(i_src), .i_tag(i_tag), .i_taken(w_div_taken), .o_busy(w_div_busy),
    .o_done(w_div_done), .o_res(w_div_res), .o_tag(w_div_tag)
  );

  muldiv_result_merge u_result_merge (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_mul_valid(w_mul_valid),
    .i_mul_prod(w_mul_prod), .i_mul_op(w_mul_op), .i_mul_tag(w_mul_tag),
    .i_div_done(w_div_done), .i_div_res(w_div_res), .i_div_tag(w_div_tag),
    .o_div_taken(w_div_taken), .o_valid(o_valid), .o_res(o_res), .o_tag(o_tag)
  );

endmodule

// ==== hw/muldiv_result_merge.sv ====
`include "muldiv_consts.svh"

module muldiv_result_merge (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_mul_valid,
  input  logic [2*`MD_XLEN-1:0]    i_mul_prod,
  input  muldiv_op_pkg::op_t       i_mul_op,
  input  muldiv_tag_pkg::rd_tag_t  i_mul_tag,
  input  logic                     i_div_done,
  input  logic [`MD_XLEN-1:0]      i_div_res,
  input  muldiv_tag_pkg::rd_tag_t  i_div_tag,
  output logic                     o_div_taken,
  output logic                     o_valid,
  output logic [`MD_XLEN-1:0]      o_res,
  output muldiv_tag_pkg::rd_tag_t  o_tag
);

  localparam int XLEN = `MD_XLEN;

  typedef struct packed {
    logic [XLEN-1:0]         res;
    muldiv_tag_pkg::rd_tag_t tag;
  } wb_t;

  logic            w_mul_hi;
  logic [XLEN-1:0] w_mul_res;
  logic            w_take_div;
  wb_t             w_wb;
  wb_t             r_wb;
  logic            r_valid;

  assign w_mul_hi  = (i_mul_op == muldiv_op_pkg::OP_MULH) ||
                     (i_mul_op == muldiv_op_pkg::OP_MULHSU) ||
                     (i_mul_op == muldiv_op_pkg::OP_MULHU);
  assign w_mul_res = w_mul_hi ? i_mul_prod[XLEN +: XLEN] : i_mul_prod[XLEN-1:0];

  // multiply wins, divider keeps holding
  assign w_take_div  = i_div_done & ~i_mul_valid;
  assign o_div_taken = w_take_div;

  assign w_wb = i_mul_valid ? '{res: w_mul_res, tag: i_mul_tag}
                            : '{res: i_div_res, tag: i_div_tag};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) r_valid <= 1'b0;
    else            r_valid <= i_mul_valid | w_take_div;
  end

  always_ff @(posedge i_clk) begin
    r_wb <= w_wb;
  end

  assign o_valid = r_valid;
  assign o_res   = r_wb.res;
  assign o_tag   = r_wb.tag;

endmodule

// ==== hw/muldiv_tag_pkg.sv ====
`include "muldiv_consts.svh"

package muldiv_tag_pkg;

  typedef enum logic {
    REG_GPR = 1'b0,
    REG_FPR = 1'b1
  } reg_t;

  typedef struct packed {
    logic [`MD_RNID_W-1:0]  rnid;      // renamed destination
    reg_t                   rtype;
    logic [`MD_ENTRY_N-1:0] index_oh;  // issue-queue entry
  } rd_tag_t;

endpackage

// ==== list.f ====
+incdir+hw
hw/muldiv_op_pkg.sv
hw/muldiv_tag_pkg.sv
hw/mul_pipe.sv
hw/div_unit.sv
hw/muldiv_result_merge.sv
hw/muldiv_pipe.sv
tests/muldiv_chk.sv
tests/muldiv_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module muldiv_tb \
  -Mdir obj_dir -o muldiv_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/muldiv_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

// ==== tests/muldiv_chk.sv ====
module muldiv_chk (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_valid,
  input  muldiv_op_pkg::op_t i_op,
  input  logic               i_stall,
  input  logic               i_res_valid,
  input  logic               i_div_busy,
  input  logic               i_div_done
);
  timeunit 1ns;
  timeprecision 1ps;

  logic w_mul_issue;

  assign w_mul_issue = i_valid && (i_op inside {muldiv_op_pkg::OP_MUL, muldiv_op_pkg::OP_MULH,
                                               muldiv_op_pkg::OP_MULHSU, muldiv_op_pkg::OP_MULHU});

  a_stall_in_reset: assert property (@(posedge i_clk) !i_reset_n |-> !i_stall)
    else $error("o_stall high during reset");

  a_no_issue_on_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_valid |-> !i_stall) else $error("issue while stalled");

  // mul pipe plus writeback register
  a_mul_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_mul_issue |-> ##5 i_res_valid) else $error("multiply result not seen 5 cycles after issue");

  a_done_not_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_div_done |-> !i_div_busy) else $error("divider done and busy together");

endmodule

bind muldiv_pipe muldiv_chk u_chk (
  .i_clk(i_clk),
  .i_reset_n(i_reset_n),
  .i_valid(i_valid),
  .i_op(i_op),
  .i_stall(o_stall),
  .i_res_valid(o_valid),
  .i_div_busy(w_div_busy),
  .i_div_done(w_div_done)
);

// ==== tests/muldiv_tb.sv ====
`include "muldiv_consts.svh"

module muldiv_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 20;
  localparam int N_OPS           = 2000;
  localparam int WATCHDOG_CYCLES = N_OPS * 40 + 1000;
  localparam int N_RNID          = 1 << `MD_RNID_W;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_valid;
  muldiv_op_pkg::op_t       i_op;
  muldiv_op_pkg::operands_t i_src;
  muldiv_tag_pkg::rd_tag_t  i_tag;
  logic                     o_stall;
  logic                     o_valid;
  logic [`MD_XLEN-1:0]      o_res;
  muldiv_tag_pkg::rd_tag_t  o_tag;

  logic [31:0]              rng;
  int                       cycle;
  int                       n_issued;
  int                       n_pending;
  logic [`MD_RNID_W-1:0]    next_rnid;

  // expected results, indexed by rnid
  logic [`MD_XLEN-1:0]      exp_res     [N_RNID];
  muldiv_tag_pkg::rd_tag_t  exp_tag     [N_RNID];
  muldiv_op_pkg::op_t       exp_op      [N_RNID];
  int                       exp_cycle   [N_RNID];
  bit                       exp_dz      [N_RNID];
  bit                       exp_pending [N_RNID];

  muldiv_pipe dut0 (
    .i_clk(i_clk),
    .i_reset_n(i_reset_n),
    .i_valid(i_valid),
    .i_op(i_op),
    .i_src(i_src),
    .i_tag(i_tag),
    .o_stall(o_stall),
    .o_valid(o_valid),
    .o_res(o_res),
    .o_tag(o_tag)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // a quarter of the operands are corner values
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] != 2'd0) return next_rand();
    case (r[3:2])
      2'd0:    return 32'h0000_0000;
      2'd1:    return 32'hffff_ffff;
      2'd2:    return 32'h8000_0000;
      default: return 32'h0000_0001;
    endcase
  endfunction

  function automatic bit is_mul_op(input muldiv_op_pkg::op_t op);
    return op inside {muldiv_op_pkg::OP_MUL, muldiv_op_pkg::OP_MULH,
                      muldiv_op_pkg::OP_MULHSU, muldiv_op_pkg::OP_MULHU};
  endfunction

  // ==========================================================================
  // reference model, RV32M rules
  // ==========================================================================
  function automatic logic [31:0] model_result(input muldiv_op_pkg::op_t op,
                                               input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sp;
    logic signed [63:0] sp_su;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        up;
    bit                 ovf;
    sa    = {{32{a[31]}}, a};
    sb    = {{32{b[31]}}, b};
    ua    = {32'h0, a};
    ub    = {32'h0, b};
    ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    sp    = sa * sb;
    sp_su = sa * $signed(ub);
    up    = ua * ub;
    case (op)
      muldiv_op_pkg::OP_MUL:    return up[31:0];
      muldiv_op_pkg::OP_MULH:   return sp[63:32];
      muldiv_op_pkg::OP_MULHSU: return sp_su[63:32];
      muldiv_op_pkg::OP_MULHU:  return up[63:32];
      muldiv_op_pkg::OP_DIV: begin
        if (b == 32'h0) return 32'hffff_ffff;
        if (ovf) return a;
        sp = sa / sb;
        return sp[31:0];
      end
      muldiv_op_pkg::OP_DIVU: begin
        if (b == 32'h0) return 32'hffff_ffff;
        up = ua / ub;
        return up[31:0];
      end
      muldiv_op_pkg::OP_REM: begin
        if (b == 32'h0) return a;
        if (ovf) return 32'h0;
        sp = sa % sb;  // sign of dividend
        return sp[31:0];
      end
      default: begin
        if (b == 32'h0) return a;
        up = ua % ub;
        return up[31:0];
      end
    endcase
  endfunction

  task automatic check_output();
    int r;
    int lat;
    if (o_valid) begin
      r = o_tag.rnid;
      if (!exp_pending[r]) fail_run($sformatf("result for rnid %0d that is not outstanding", r));
      check_value("o_res", o_res, exp_res[r]);
      check_value("o_tag", 64'(o_tag), 64'(exp_tag[r]));
      lat = cycle - exp_cycle[r];
      if (is_mul_op(exp_op[r])) begin
        check_value("mul latency", lat, 5);
      end else begin
        check_value("o_stall", o_stall, 1'b0);  // divider free again
        if (exp_dz[r] && lat > 8) fail_run("divide by zero did not take the early exit");
        else if (lat > 40) fail_run("divide result took far too long");
      end
      exp_pending[r] = 1'b0;
      n_pending--;
    end
  endtask

  task automatic drive_issue();
    logic [31:0]              r;
    muldiv_op_pkg::op_t       op;
    muldiv_op_pkg::operands_t src;
    muldiv_tag_pkg::rd_tag_t  tag;
    i_valid = 1'b0;
    if (o_stall || n_issued >= N_OPS) return;
    r = next_rand();
    if (r[1:0] == 2'd0 || exp_pending[next_rnid]) return;
    op           = muldiv_op_pkg::op_t'(r[4:2]);
    src.rs1      = pick_operand();
    src.rs2      = pick_operand();
    tag.rnid     = next_rnid;
    tag.rtype    = muldiv_tag_pkg::reg_t'(r[5]);
    tag.index_oh = '0;
    tag.index_oh[r[8:6]] = 1'b1;
    exp_res[next_rnid]     = model_result(op, src.rs1, src.rs2);
    exp_tag[next_rnid]     = tag;
    exp_op[next_rnid]      = op;
    exp_cycle[next_rnid]   = cycle;
    exp_dz[next_rnid]      = (src.rs2 == 32'h0);
    exp_pending[next_rnid] = 1'b1;
    i_valid   = 1'b1;
    i_op      = op;
    i_src     = src;
    i_tag     = tag;
    next_rnid = next_rnid + 1'b1;
    n_issued++;
    n_pending++;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before all operations completed");
  end

  initial begin
    int drain;
    i_clk     = 1'b0;
    i_reset_n = 1'b0;
    i_valid   = 1'b0;
    i_op      = muldiv_op_pkg::OP_MUL;
    i_src     = '0;
    i_tag     = '0;
    rng       = 32'hc59a;
    cycle     = 0;
    n_issued  = 0;
    n_pending = 0;
    next_rnid = '0;
    for (int k = 0; k < N_RNID; k++) exp_pending[k] = 1'b0;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    while (n_issued < N_OPS) begin
      @(negedge i_clk);
      cycle++;
      check_output();
      drive_issue();
    end
    @(negedge i_clk);
    i_valid = 1'b0;
    drain   = 0;
    while (n_pending != 0 && drain < 100) begin
      cycle++;
      check_output();
      drain++;
      @(negedge i_clk);
    end
    if (n_pending != 0) begin
      fail_run($sformatf("%0d results still outstanding at the end of the run", n_pending));
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
